// File: hw/rvv_dispatch_pkg.sv
//================================================
// micro-op types, instruction word views and the
// vector encodings shared by the dispatch stages
//================================================
`default_nettype none

package rvv_dispatch_pkg;

    localparam int REG_IDX_W = 5;

    // operand selectors, same bit order as uop_class_e
    localparam int OPND_VS1 = 0;
    localparam int OPND_VS2 = 1;
    localparam int OPND_VD  = 2;

    // bit 2 reads vd, bit 1 reads vs2, bit 0 reads vs1
    typedef enum logic [2:0] {
        XXX = 3'b000,
        XXV = 3'b001,
        XVX = 3'b010,
        XVV = 3'b011,
        VXX = 3'b100,
        VVX = 3'b110,
        VVV = 3'b111
    } uop_class_e;

    typedef enum logic [1:0] {
        ALU = 2'd0,
        MAC = 2'd1,
        LSU = 2'd2
    } exe_unit_e;

    typedef struct packed {
        logic                 valid;
        uop_class_e           uop_class;
        exe_unit_e            uop_exe_unit;
        logic [REG_IDX_W-1:0] vd_index;
        logic [REG_IDX_W-1:0] vs2_index;
        logic [REG_IDX_W-1:0] vs1_index;
        logic [31:0]          inst;
    } strct_uop_t;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } arith_fmt_t;

    // vs2 holds the stride or index register, vd the data register
    typedef struct packed {
        logic [2:0] nf;
        logic       mew;
        logic [1:0] mop;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] rs1;
        logic [2:0] width;
        logic [4:0] vd;
        logic [6:0] opcode;
    } mem_fmt_t;

    typedef union packed {
        arith_fmt_t arith;
        mem_fmt_t   mem;
    } inst_word_u;

    localparam logic [6:0] OP_V        = 7'b1010111;
    localparam logic [6:0] OP_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OP_STORE_FP = 7'b0100111;

    localparam logic [2:0] OPIVV = 3'b000;
    localparam logic [2:0] OPMVV = 3'b010;
    localparam logic [2:0] OPIVI = 3'b011;
    localparam logic [2:0] OPIVX = 3'b100;
    localparam logic [2:0] OPMVX = 3'b110;

    // multiply-accumulate group, all in the OPM space
    localparam logic [5:0] F6_VMADD  = 6'b101001;
    localparam logic [5:0] F6_VNMSUB = 6'b101011;
    localparam logic [5:0] F6_VMACC  = 6'b101101;
    localparam logic [5:0] F6_VNMSAC = 6'b101111;
    localparam logic [5:0] VMV_V     = 6'b010111;

    typedef struct packed {
        logic vr_limit;
        logic pu_limit;
    } arch_hazard_t;

endpackage

`default_nettype wire

// File: hw/uop_if.sv
//================================================
// decoded micro-op pair between decode, hazard
// check and issue
//================================================
`timescale 1ns/1ps
`default_nettype none

interface uop_if;

    import rvv_dispatch_pkg::*;

    // one strobe per slot through uop[i].valid
    strct_uop_t [1:0] uop;

    modport decode (
        output uop
    );

    modport hazard (
        input uop
    );

    modport issue (
        input uop
    );

endinterface

`default_nettype wire

// File: hw/uop_decode.sv
//================================================
// registered decode of two vector instruction
// words into structural micro-ops
//================================================
`timescale 1ns/1ps
`default_nettype none

module uop_decode (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [1:0]       inst_valid,
    input  logic [1:0][31:0] inst_word,
    uop_if.decode            uops
);

    import rvv_dispatch_pkg::*;

    strct_uop_t [1:0] uop_nxt;

    function automatic strct_uop_t decode_word(input logic vld, input logic [31:0] word);
        inst_word_u w;
        strct_uop_t u;
        logic       mac_op;
        w      = word;
        u      = '0;
        mac_op = 1'b0;
        // no strobe leaves an all-zero micro-op
        if (vld) begin
            u.inst = word;
            case (w.arith.opcode)
                OP_V: begin
                    u.valid     = 1'b1;
                    u.vd_index  = w.arith.vd;
                    u.vs2_index = w.arith.vs2;
                    u.vs1_index = w.arith.vs1;
                    mac_op = (w.arith.funct3 inside {OPMVV, OPMVX}) &&
                             (w.arith.funct6 inside {F6_VMACC, F6_VNMSAC, F6_VMADD, F6_VNMSUB});
                    if (mac_op) begin
                        u.uop_exe_unit = MAC;
                        u.uop_class    = (w.arith.funct3 == OPMVV) ? VVV : VVX;
                    end else if (w.arith.funct6 == VMV_V &&
                                 w.arith.funct3 inside {OPIVV, OPIVX, OPIVI}) begin
                        // vmv.v.v reads vs1 only, .v.x and .v.i nothing
                        u.uop_class = (w.arith.funct3 == OPIVV) ? XXV : XXX;
                    end else if (w.arith.funct3 inside {OPIVV, OPMVV}) begin
                        u.uop_class = XVV;
                    end else begin
                        u.uop_class = XVX;
                    end
                end
                OP_LOAD_FP: begin
                    u.valid        = 1'b1;
                    u.uop_exe_unit = LSU;
                    u.vd_index     = w.mem.vd;
                    u.vs2_index    = w.mem.vs2;
                    // mop bit 0 marks the indexed forms
                    u.uop_class    = w.mem.mop[0] ? XVX : XXX;
                end
                OP_STORE_FP: begin
                    u.valid        = 1'b1;
                    u.uop_exe_unit = LSU;
                    u.vd_index     = w.mem.vd;
                    u.vs2_index    = w.mem.vs2;
                    u.uop_class    = w.mem.mop[0] ? VVX : VXX;
                end
                default: begin
                    u.valid = 1'b0;
                end
            endcase
        end
        return u;
    endfunction

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            uop_nxt[s] = decode_word(inst_valid[s], inst_word[s]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uops.uop <= '0;
        end else begin
            uops.uop <= uop_nxt;
        end
    end

endmodule

`default_nettype wire

// File: hw/dispatch_structure_hazard.sv
//================================================
// register file read port sharing, operand
// routing and structure hazard detection
//================================================
`timescale 1ns/1ps
`default_nettype none

module dispatch_structure_hazard #(
    parameter int NUM_VRF_RD = 4
) (
    uop_if.hazard                                                 uops,
    output logic [NUM_VRF_RD-1:0][rvv_dispatch_pkg::REG_IDX_W-1:0] rd_index,
    output logic [1:0][2:0][$clog2(NUM_VRF_RD)-1:0]                route,
    output rvv_dispatch_pkg::arch_hazard_t                         arch_hazard
);

    import rvv_dispatch_pkg::*;

    localparam int PW = $clog2(NUM_VRF_RD);

    logic both_valid;

    assign both_valid = uops.uop[0].valid & uops.uop[1].valid;

    // a single MAC unit, whatever the port count
    assign arch_hazard.pu_limit = both_valid &&
                                  uops.uop[0].uop_exe_unit == MAC &&
                                  uops.uop[1].uop_exe_unit == MAC;

    generate
        if (NUM_VRF_RD == 6) begin : g_fixed_ports
            // three private ports per slot: vs1, vs2, vd
            always_comb begin
                logic [2:0][REG_IDX_W-1:0] idx;
                for (int s = 0; s < 2; s++) begin
                    idx = {uops.uop[s].vd_index, uops.uop[s].vs2_index, uops.uop[s].vs1_index};
                    for (int k = 0; k < 3; k++) begin
                        route[s][k]       = PW'(3 * s + k);
                        rd_index[3*s + k] = idx[k];
                    end
                end
            end

            assign arch_hazard.vr_limit = 1'b0;
        end else begin : g_shared_ports
            logic vr_pair;

            // slot s owns port 2s, shares port 2s+1, and borrows the other
            // slot's second port for vd when it is VVV
            always_comb begin
                logic [2:0]                rd;
                logic [2:0][REG_IDX_W-1:0] idx;
                logic [PW-1:0]             prim;
                logic [PW-1:0]             sec;
                logic [PW-1:0]             third;
                rd_index = '0;
                route    = '0;
                // slot 1 first so that slot 0 wins a shared port
                for (int s = 1; s >= 0; s--) begin
                    rd    = uops.uop[s].uop_class;
                    idx   = {uops.uop[s].vd_index, uops.uop[s].vs2_index, uops.uop[s].vs1_index};
                    prim  = PW'(2 * s);
                    sec   = PW'(2 * s + 1);
                    third = PW'(3 - 2 * s);
                    route[s][OPND_VS2] = prim;
                    if (rd[OPND_VS2]) begin
                        route[s][OPND_VS1] = sec;
                        route[s][OPND_VD]  = rd[OPND_VS1] ? third : sec;
                    end else begin
                        // VXX and XXV only need one port
                        route[s][OPND_VS1] = prim;
                        route[s][OPND_VD]  = prim;
                    end
                    for (int k = 0; k < 3; k++) begin
                        if (rd[k]) begin
                            rd_index[route[s][k]] = idx[k];
                        end
                    end
                end
            end

            // pairs that need five or six reads
            always_comb begin
                case ({uops.uop[0].uop_class, uops.uop[1].uop_class})
                    {VVV, VVV},
                    {VVV, XVV},
                    {VVV, VVX},
                    {XVV, VVV},
                    {VVX, VVV}: vr_pair = 1'b1;
                    default:    vr_pair = 1'b0;
                endcase
            end

            assign arch_hazard.vr_limit = both_valid & vr_pair;
        end
    endgenerate

endmodule

`default_nettype wire

// File: hw/vrf.sv
//================================================
// 32-entry vector register file, parameterized
// read ports and one write port
//================================================
`timescale 1ns/1ps
`default_nettype none

module vrf #(
    parameter int NUM_VRF_RD = 4,
    parameter int VLEN       = 32
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [NUM_VRF_RD-1:0][rvv_dispatch_pkg::REG_IDX_W-1:0] rd_index,
    output logic [NUM_VRF_RD-1:0][VLEN-1:0]                        rd_data,
    input  logic                                                  wr_en,
    input  logic [rvv_dispatch_pkg::REG_IDX_W-1:0]                 wr_index,
    input  logic [VLEN-1:0]                                        wr_data
);

    import rvv_dispatch_pkg::*;

    localparam int NUM_REGS = 1 << REG_IDX_W;

    logic [VLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_index] <= wr_data;
        end
    end

    // same-cycle read of a written entry sees the old value
    always_comb begin
        for (int p = 0; p < NUM_VRF_RD; p++) begin
            rd_data[p] = regs[rd_index[p]];
        end
    end

endmodule

`default_nettype wire

// File: hw/dispatch_issue.sv
//================================================
// operand gathering, issue decision and the
// registered issue and retry outputs
//================================================
`timescale 1ns/1ps
`default_nettype none

module dispatch_issue #(
    parameter int NUM_VRF_RD = 4,
    parameter int VLEN       = 32
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    uop_if.issue                                           uops,
    input  logic [1:0][2:0][$clog2(NUM_VRF_RD)-1:0]         route,
    input  rvv_dispatch_pkg::arch_hazard_t                  arch_hazard,
    input  logic [NUM_VRF_RD-1:0][VLEN-1:0]                 rd_data,
    output logic [1:0]                                     issue_valid,
    output rvv_dispatch_pkg::uop_class_e [1:0]              issue_class,
    output rvv_dispatch_pkg::exe_unit_e [1:0]               issue_unit,
    output logic [1:0][rvv_dispatch_pkg::REG_IDX_W-1:0]     issue_vd_index,
    output logic [1:0][VLEN-1:0]                           issue_vd_data,
    output logic [1:0][VLEN-1:0]                           issue_vs2_data,
    output logic [1:0][VLEN-1:0]                           issue_vs1_data,
    output logic                                           retry_valid,
    output logic [31:0]                                    retry_word
);

    import rvv_dispatch_pkg::*;

    logic [1:0][2:0][VLEN-1:0] opnd;
    logic [1:0]                issue_go;
    logic                      hazard;

    // operands not read by the class stay zero
    always_comb begin
        logic [2:0] cls;
        for (int s = 0; s < 2; s++) begin
            cls = uops.uop[s].uop_class;
            for (int k = 0; k < 3; k++) begin
                opnd[s][k] = cls[k] ? rd_data[route[s][k]] : '0;
            end
        end
    end

    assign hazard      = arch_hazard.vr_limit | arch_hazard.pu_limit;
    assign issue_go[0] = uops.uop[0].valid;
    assign issue_go[1] = uops.uop[1].valid & ~hazard;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= '0;
            retry_valid <= 1'b0;
        end else begin
            issue_valid <= issue_go;
            retry_valid <= uops.uop[1].valid & hazard;
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            issue_class[s]    <= uops.uop[s].uop_class;
            issue_unit[s]     <= uops.uop[s].uop_exe_unit;
            issue_vd_index[s] <= uops.uop[s].vd_index;
            issue_vd_data[s]  <= opnd[s][OPND_VD];
            issue_vs2_data[s] <= opnd[s][OPND_VS2];
            issue_vs1_data[s] <= opnd[s][OPND_VS1];
        end
        retry_word <= uops.uop[1].inst;
    end

endmodule

`default_nettype wire

// File: hw/rvv_dispatch_top.sv
//================================================
// dual-issue vector dispatch front end: decode,
// hazard check, register file and issue
//================================================
`timescale 1ns/1ps
`default_nettype none

module rvv_dispatch_top #(
    parameter int NUM_VRF_RD = 4,
    parameter int VLEN       = 32
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [1:0]                                 inst_valid,
    input  logic [1:0][31:0]                           inst_word,
    input  logic                                       wr_en,
    input  logic [rvv_dispatch_pkg::REG_IDX_W-1:0]      wr_index,
    input  logic [VLEN-1:0]                            wr_data,
    output logic [1:0]                                 issue_valid,
    output rvv_dispatch_pkg::uop_class_e [1:0]          issue_class,
    output rvv_dispatch_pkg::exe_unit_e [1:0]           issue_unit,
    output logic [1:0][rvv_dispatch_pkg::REG_IDX_W-1:0] issue_vd_index,
    output logic [1:0][VLEN-1:0]                       issue_vd_data,
    output logic [1:0][VLEN-1:0]                       issue_vs2_data,
    output logic [1:0][VLEN-1:0]                       issue_vs1_data,
    output logic                                       retry_valid,
    output logic [31:0]                                retry_word
);

    import rvv_dispatch_pkg::*;

    logic [NUM_VRF_RD-1:0][REG_IDX_W-1:0]    rd_index;
    logic [NUM_VRF_RD-1:0][VLEN-1:0]         rd_data;
    logic [1:0][2:0][$clog2(NUM_VRF_RD)-1:0] route;
    arch_hazard_t                            arch_hazard;

    uop_if u_uops ();

    uop_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .uops       (u_uops.decode)
    );

    dispatch_structure_hazard #(
        .NUM_VRF_RD (NUM_VRF_RD)
    ) u_hazard (
        .uops        (u_uops.hazard),
        .rd_index    (rd_index),
        .route       (route),
        .arch_hazard (arch_hazard)
    );

    vrf #(
        .NUM_VRF_RD (NUM_VRF_RD),
        .VLEN       (VLEN)
    ) u_vrf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data)
    );

    dispatch_issue #(
        .NUM_VRF_RD (NUM_VRF_RD),
        .VLEN       (VLEN)
    ) u_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .uops           (u_uops.issue),
        .route          (route),
        .arch_hazard    (arch_hazard),
        .rd_data        (rd_data),
        .issue_valid    (issue_valid),
        .issue_class    (issue_class),
        .issue_unit     (issue_unit),
        .issue_vd_index (issue_vd_index),
        .issue_vd_data  (issue_vd_data),
        .issue_vs2_data (issue_vs2_data),
        .issue_vs1_data (issue_vs1_data),
        .retry_valid    (retry_valid),
        .retry_word     (retry_word)
    );

endmodule

`default_nettype wire

// File: test/rvv_dispatch_sva.sv
//================================================
// bound protocol checks on the issue and retry
// outputs of the dispatch top level
//================================================
`timescale 1ns/1ps
`default_nettype none

module rvv_dispatch_sva (
    input logic            clk,
    input logic            rst_n,
    input logic [1:0]      issue_valid,
    input logic [1:0][1:0] issue_unit,
    input logic            retry_valid
);

    import rvv_dispatch_pkg::*;

    // number of failed properties
    int unsigned sva_failures = 0;

    no_strobe_in_reset: assert property (@(posedge clk)
        !rst_n |-> (issue_valid == 2'b00 && !retry_valid))
    else begin
        sva_failures++;
        $error("issue or retry strobe while reset is asserted");
    end

    // a retry only ever replaces slot 1
    retry_only_slot1: assert property (@(posedge clk) disable iff (!rst_n)
        retry_valid |-> issue_valid == 2'b01)
    else begin
        sva_failures++;
        $error("retry without slot 0 issue, or with slot 1 issued");
    end

    single_mac: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_valid[1] && issue_unit[1] == MAC) |-> !(issue_valid[0] && issue_unit[0] == MAC))
    else begin
        sva_failures++;
        $error("both slots issued to the single MAC unit");
    end

endmodule

`default_nettype wire

// File: test/tb_rvv_dispatch.sv
//================================================
// testbench for the dual-issue dispatch: stimulus,
// reference decode and hazard model, checks
//================================================
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_dispatch;

    import rvv_dispatch_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_KINDS    = 12;
    localparam int NUM_RANDOM   = 100;
    // about twice the 303 cycles of stimulus
    localparam int CYCLE_LIMIT  = 600;

    typedef struct packed {
        logic [1:0]       iv;
        logic [1:0][2:0]  cls;
        logic [1:0][1:0]  unit;
        logic [1:0][4:0]  vd;
        logic [1:0][31:0] dvd;
        logic [1:0][31:0] dvs2;
        logic [1:0][31:0] dvs1;
        logic             rv;
        logic [31:0]      rw;
    } expect_t;

    logic             clk;
    logic             rst_n;
    logic [1:0]       inst_valid;
    logic [1:0][31:0] inst_word;
    logic             wr_en;
    logic [4:0]       wr_index;
    logic [31:0]      wr_data;
    logic [1:0]       issue_valid;
    logic [1:0][2:0]  issue_class;
    logic [1:0][1:0]  issue_unit;
    logic [1:0][4:0]  issue_vd_index;
    logic [1:0][31:0] issue_vd_data;
    logic [1:0][31:0] issue_vs2_data;
    logic [1:0][31:0] issue_vs1_data;
    logic             retry_valid;
    logic [31:0]      retry_word;

    logic [31:0] model [32];
    expect_t     exp_q [$];
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;

    rvv_dispatch_top #(
        .NUM_VRF_RD (4),
        .VLEN       (32)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst_word      (inst_word),
        .wr_en          (wr_en),
        .wr_index       (wr_index),
        .wr_data        (wr_data),
        .issue_valid    (issue_valid),
        .issue_class    (issue_class),
        .issue_unit     (issue_unit),
        .issue_vd_index (issue_vd_index),
        .issue_vd_data  (issue_vd_data),
        .issue_vs2_data (issue_vs2_data),
        .issue_vs1_data (issue_vs1_data),
        .retry_valid    (retry_valid),
        .retry_word     (retry_word)
    );

    bind rvv_dispatch_top rvv_dispatch_sva u_sva (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_unit  (issue_unit),
        .retry_valid (retry_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] arith_word(input logic [5:0] f6, input logic [2:0] f3,
                                               input logic [4:0] vd, input logic [4:0] vs2,
                                               input logic [4:0] vs1);
        return {f6, 1'b1, vs2, vs1, f3, vd, OP_V};
    endfunction

    // unit-stride unless indexed with fixed rs1 and width
    function automatic logic [31:0] mem_word(input logic [6:0] opc, input logic indexed,
                                             input logic [4:0] vd, input logic [4:0] vs2);
        return {3'b000, 1'b0, 1'b0, indexed, 1'b1, vs2, 5'd2, 3'b110, vd, opc};
    endfunction

    function automatic logic [31:0] make_word(input int kind);
        logic [4:0]  vd;
        logic [4:0]  vs2;
        logic [4:0]  vs1;
        logic [31:0] w;
        vd  = 5'($urandom);
        vs2 = 5'($urandom);
        vs1 = 5'($urandom);
        case (kind)
            0:       w = arith_word(F6_VMACC, OPMVV, vd, vs2, vs1);
            1:       w = arith_word(F6_VNMSAC, OPMVX, vd, vs2, vs1);
            2:       w = mem_word(OP_STORE_FP, 1'b1, vd, vs2);
            3:       w = arith_word(6'b000000, OPIVV, vd, vs2, vs1);
            4:       w = arith_word(6'b000000, OPIVX, vd, vs2, vs1);
            5:       w = mem_word(OP_LOAD_FP, 1'b1, vd, vs2);
            6:       w = arith_word(VMV_V, OPIVV, vd, 5'd0, vs1);
            7:       w = mem_word(OP_LOAD_FP, 1'b0, vd, vs2);
            8:       w = mem_word(OP_STORE_FP, 1'b0, vd, vs2);
            10:      w = arith_word(VMV_V, OPIVI, vd, 5'd0, vs1);
            11:      w = arith_word(F6_VNMSUB, OPMVV, vd, vs2, vs1);
            // not a vector opcode
            default: w = {$urandom} & 32'hffff_ff80 | 32'h0000_0033;
        endcase
        return w;
    endfunction

    // result is {valid, reads vd, reads vs2, reads vs1, unit}
    function automatic logic [5:0] ref_decode(input logic [31:0] w);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [5:0] f6;
        logic [2:0] cls;
        logic [1:0] unit;
        logic       vld;
        opc  = w[6:0];
        f3   = w[14:12];
        f6   = w[31:26];
        vld  = 1'b1;
        cls  = 3'b000;
        unit = ALU;
        if (opc == OP_V) begin
            if ((f3 == OPMVV || f3 == OPMVX) && (f6 == F6_VMACC || f6 == F6_VNMSAC ||
                                                 f6 == F6_VMADD || f6 == F6_VNMSUB)) begin
                unit = MAC;
                cls  = (f3 == OPMVV) ? 3'b111 : 3'b110;
            end else if (f6 == VMV_V && (f3 == OPIVV || f3 == OPIVX || f3 == OPIVI)) begin
                cls = (f3 == OPIVV) ? 3'b001 : 3'b000;
            end else if (f3 == OPIVV || f3 == OPMVV) begin
                cls = 3'b011;
            end else begin
                cls = 3'b010;
            end
        end else if (opc == OP_LOAD_FP) begin
            unit = LSU;
            cls  = w[26] ? 3'b010 : 3'b000;
        end else if (opc == OP_STORE_FP) begin
            unit = LSU;
            cls  = w[26] ? 3'b110 : 3'b100;
        end else begin
            vld = 1'b0;
        end
        return {vld, cls, unit};
    endfunction

    // five or more register reads do not fit four ports
    function automatic logic port_limit(input logic [2:0] c0, input logic [2:0] c1);
        return (c0 == VVV && (c1 == VVV || c1 == XVV || c1 == VVX)) ||
               (c1 == VVV && (c0 == XVV || c0 == VVX));
    endfunction

    task automatic check_field(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs(input expect_t e);
        check_field("issue_valid", 32'(issue_valid), 32'(e.iv));
        for (int s = 0; s < 2; s++) begin
            if (e.iv[s]) begin
                check_field($sformatf("slot %0d class", s), 32'(issue_class[s]), 32'(e.cls[s]));
                check_field($sformatf("slot %0d unit", s), 32'(issue_unit[s]), 32'(e.unit[s]));
                check_field($sformatf("slot %0d vd index", s), 32'(issue_vd_index[s]),
                            32'(e.vd[s]));
                check_field($sformatf("slot %0d vd data", s), issue_vd_data[s], e.dvd[s]);
                check_field($sformatf("slot %0d vs2 data", s), issue_vs2_data[s], e.dvs2[s]);
                check_field($sformatf("slot %0d vs1 data", s), issue_vs1_data[s], e.dvs1[s]);
            end
        end
        check_field("retry_valid", 32'(retry_valid), 32'(e.rv));
        if (e.rv) begin
            check_field("retry_word", retry_word, e.rw);
        end
    endtask

    // check the pair from two cycles ago then drive and predict the next one
    task automatic drive_cycle(input logic [1:0] vld, input logic [1:0][31:0] words,
                               input logic we, input logic [4:0] wi, input logic [31:0] wd);
        expect_t         e;
        logic [1:0][5:0] d;
        logic [1:0]      ok;
        logic            hz;
        logic [31:0]     w;
        @(negedge clk);
        if (exp_q.size() == 2) begin
            check_outputs(exp_q.pop_front());
        end
        inst_valid = vld;
        inst_word  = words;
        wr_en      = we;
        wr_index   = wi;
        wr_data    = wd;
        if (we) begin
            model[wi] = wd;
        end
        d[0]  = ref_decode(words[0]);
        d[1]  = ref_decode(words[1]);
        ok[0] = vld[0] & d[0][5];
        ok[1] = vld[1] & d[1][5];
        hz    = ok[0] & ok[1] & (port_limit(d[0][4:2], d[1][4:2]) ||
                                 (d[0][1:0] == MAC && d[1][1:0] == MAC));
        e.iv = {ok[1] & ~hz, ok[0]};
        e.rv = ok[1] & hz;
        e.rw = words[1];
        for (int s = 0; s < 2; s++) begin
            w         = words[s];
            e.cls[s]  = d[s][4:2];
            e.unit[s] = d[s][1:0];
            e.vd[s]   = w[11:7];
            e.dvd[s]  = d[s][4] ? model[w[11:7]] : 32'd0;
            e.dvs2[s] = d[s][3] ? model[w[24:20]] : 32'd0;
            e.dvs1[s] = d[s][2] ? model[w[19:15]] : 32'd0;
        end
        exp_q.push_back(e);
    endtask

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [4:0]  r;
        logic [31:0] v;
        logic [1:0]  vld;
        int unsigned sva_fails;
        void'($urandom(32'h404b_7b7c));
        rst_n      = 1'b0;
        inst_valid = '0;
        inst_word  = '0;
        wr_en      = 1'b0;
        wr_index   = '0;
        wr_data    = '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        // fill the register file
        for (int i = 0; i < 32; i++) begin
            drive_cycle(2'b00, '0, 1'b1, 5'(i), $urandom);
        end
        // every kind against every kind on back-to-back cycles
        for (int a = 0; a < NUM_KINDS; a++) begin
            for (int b = 0; b < NUM_KINDS; b++) begin
                drive_cycle(2'b11, {make_word(b), make_word(a)}, 1'b0, '0, '0);
            end
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            vld = ($urandom % 4 == 0) ? 2'($urandom) : 2'b11;
            drive_cycle(vld, {make_word(int'($urandom % NUM_KINDS)),
                              make_word(int'($urandom % NUM_KINDS))}, 1'b0, '0, '0);
        end
        // write a register on the edge that decodes a pair reading it
        // and overwrite it again in the cycle of that read
        for (int n = 0; n < 4; n++) begin
            r = 5'($urandom);
            v = $urandom;
            drive_cycle(2'b11, {arith_word(VMV_V, OPIVV, 5'(r + 1), 5'd0, r),
                                arith_word(6'b000000, OPIVV, r, r, r)}, 1'b1, r, v);
            drive_cycle(2'b00, '0, 1'b1, r, ~v);
        end
        repeat (3) drive_cycle(2'b00, '0, 1'b0, '0, '0);
        sva_fails = DUT.u_sva.sva_failures;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/rvv_dispatch_pkg.sv
hw/uop_if.sv
hw/uop_decode.sv
hw/dispatch_structure_hazard.sv
hw/vrf.sv
hw/dispatch_issue.sv
hw/rvv_dispatch_top.sv
test/rvv_dispatch_sva.sv
test/tb_rvv_dispatch.sv

// File: run_sim.sh
#!/bin/sh
# build the dispatch testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_rvv_dispatch \
    -f files.f -Mdir obj_dir
status=0
./obj_dir/Vtb_rvv_dispatch +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log || [ "$status" -ne 0 ]; then
    exit 1
fi
grep -q "ALL TESTS PASSED" sim.log
